// ==== hw/simon_pkg.sv ====
`default_nettype none

package simon_pkg;

    localparam int color_w = 2;     // red 0, green 1, yellow 2, blue 3
    localparam int addr_w  = 5;
    localparam int seq_len = 32;    // rounds to win, also memory depth
    localparam int count_w = 6;
    localparam int phase_w = 4;     // tone phase counter width

    localparam logic [addr_w-1:0] last_step = addr_w'(seq_len - 1);

    localparam logic [count_w-1:0] count_seq = count_w'(33);  // first round on/off time
    localparam logic [count_w-1:0] dec_seq   = count_w'(1);   // speed-up per round
    localparam logic [count_w-1:0] count_key = count_w'(33);  // key window
    localparam logic [count_w-1:0] count_fin = count_w'(8);   // loss and win blink

    typedef enum logic [4:0] {
        idle, init, record, fetch, fetch_wait,
        show_on, show_off,
        key_arm, key_wait, key_check, ok_on, ok_off,
        err_led, err_on, err_off,
        loss_fetch, loss_wait, loss_show, loss_on, loss_off,
        final_on, final_off,
        win_on, win_off
    } game_state_e;

    typedef enum logic [2:0] {
        snd_red    = 3'd0,
        snd_green  = 3'd1,
        snd_yellow = 3'd2,
        snd_blue   = 3'd3,
        snd_win    = 3'd4,
        snd_loss   = 3'd5
    } sound_e;

    // speaker half-period in cycles, indexed by sound code
    localparam logic [phase_w-1:0] tone_half [6] = '{
        4'd4, 4'd5, 4'd6, 4'd7, 4'd8, 4'd3
    };

endpackage

`default_nettype wire

// ==== hw/seq_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module seq_memory (
    input  wire                           clock,
    input  wire                           rst_n,
    input  wire                           wr,
    input  wire  [simon_pkg::addr_w-1:0]  address,
    output logic [simon_pkg::color_w-1:0] data_out
);

    logic [simon_pkg::color_w-1:0] colour;                      // free-running source
    logic [simon_pkg::color_w-1:0] mem [simon_pkg::seq_len];    // one colour per round

    // the colour in flight when the strobe lands becomes the new step
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            colour <= '0;
        end else begin
            colour <= colour + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        data_out <= mem[address];   // old contents on a same-cycle write
        if (wr) begin
            mem[address] <= colour;
        end
    end

    // controller drops the strobe in the state after record
    wr_single_cycle: assert property (
        @(posedge clock) disable iff (!rst_n)
        wr |=> !wr
    );

endmodule

`default_nettype wire

// ==== hw/tone_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tone_gen (
    input  wire                clock,
    input  wire                rst_n,
    input  wire                play,
    input  simon_pkg::sound_e  sound,
    output logic               speaker
);

    logic [simon_pkg::phase_w-1:0] phase;       // cycles into current half-period
    logic                          code_ok;     // sound code has a table entry
    logic                          half_end;

    always_comb begin
        code_ok  = (sound <= simon_pkg::snd_loss);
        half_end = 1'b0;
        if (code_ok) begin
            half_end = (phase == simon_pkg::tone_half[sound] - 1'b1);
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            phase   <= '0;
            speaker <= 1'b0;
        end else if (!play) begin
            phase   <= '0;      // silent, restart from a clean phase
            speaker <= 1'b0;
        end else if (half_end) begin
            phase   <= '0;
            speaker <= ~speaker;
        end else if (code_ok) begin
            phase <= phase + 1'b1;
        end else begin
            phase <= '0;        // no pitch for codes 6 and 7
        end
    end

    // a stop request always silences the speaker on the next edge
    silent_after_stop: assert property (
        @(posedge clock) disable iff (!rst_n)
        !play |=> (!speaker && phase == '0)
    );

endmodule

`default_nettype wire

// ==== hw/game_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module game_fsm (
    input  wire                           clock,
    input  wire                           rst_n,
    input  wire                           start,
    input  wire  [3:0]                    key,
    input  wire  [simon_pkg::color_w-1:0] data_out,
    output logic                          wr,
    output logic [simon_pkg::addr_w-1:0]  address,
    output logic                          play,
    output simon_pkg::sound_e             sound,
    output logic [3:0]                    nl,
    output logic                          nloss
);

    simon_pkg::game_state_e        state;
    logic [simon_pkg::addr_w-1:0]  scan;        // step being shown or checked
    logic [simon_pkg::addr_w-1:0]  max;         // last step of this round
    logic [simon_pkg::count_w-1:0] timebase;    // LED on/off time of this round
    logic [simon_pkg::count_w-1:0] count;

    logic                          key_hit;
    logic [simon_pkg::color_w-1:0] key_idx;

    // lowest numbered key wins when several are held
    always_comb begin
        key_hit = 1'b1;
        key_idx = '0;
        casez (key)
            4'b???1: key_idx = 2'd0;
            4'b??10: key_idx = 2'd1;
            4'b?100: key_idx = 2'd2;
            4'b1000: key_idx = 2'd3;
            default: key_hit = 1'b0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state    <= simon_pkg::idle;
            scan     <= '0;
            max      <= '0;
            timebase <= '0;
            count    <= '0;
            wr       <= 1'b0;
            address  <= '0;
            play     <= 1'b0;
            sound    <= simon_pkg::snd_red;
            nl       <= '0;
            nloss    <= 1'b0;
        end else if (start) begin
            nloss <= 1'b0;          // restart from any state
            nl    <= '0;
            play  <= 1'b0;
            wr    <= 1'b0;
            state <= simon_pkg::init;
        end else begin
            case (state)
                simon_pkg::idle: begin
                    state <= simon_pkg::idle;
                end
                simon_pkg::init: begin
                    max      <= '0;
                    scan     <= '0;
                    timebase <= simon_pkg::count_seq;
                    state    <= simon_pkg::record;
                end
                simon_pkg::record: begin
                    scan    <= '0;
                    wr      <= 1'b1;        // store a new colour at max
                    address <= max;
                    state   <= simon_pkg::fetch;
                end
                simon_pkg::fetch: begin
                    wr      <= 1'b0;
                    address <= scan;
                    state   <= simon_pkg::fetch_wait;
                end
                simon_pkg::fetch_wait: begin
                    state <= simon_pkg::show_on;    // read in flight
                end
                simon_pkg::show_on: begin
                    if (!play) begin
                        nl    <= 4'b0001 << data_out;   // first cycle lights the colour
                        play  <= 1'b1;
                        sound <= simon_pkg::sound_e'({1'b0, data_out});
                        count <= timebase;
                    end else if (count == '0) begin
                        nl    <= '0;
                        play  <= 1'b0;
                        count <= timebase;
                        state <= simon_pkg::show_off;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                simon_pkg::show_off: begin
                    if (count != '0) begin
                        count <= count - 1'b1;
                    end else if (scan != max) begin
                        scan  <= scan + 1'b1;
                        state <= simon_pkg::fetch;
                    end else begin
                        scan  <= '0;
                        state <= simon_pkg::key_arm;
                    end
                end
                simon_pkg::key_arm: begin
                    count   <= simon_pkg::count_key;
                    address <= scan;
                    state   <= simon_pkg::key_wait;
                end
                simon_pkg::key_wait: begin
                    state <= simon_pkg::key_check;
                end
                simon_pkg::key_check: begin
                    if (count == '0) begin
                        nloss <= 1'b1;      // player ran out of time
                        max   <= '0;
                        state <= simon_pkg::loss_fetch;
                    end else if (key_hit) begin
                        nl    <= 4'b0001 << key_idx;
                        play  <= 1'b1;
                        sound <= simon_pkg::sound_e'({1'b0, key_idx});
                        if (key_idx == data_out) begin
                            count <= timebase;
                            state <= simon_pkg::ok_on;
                        end else begin
                            nloss <= 1'b1;
                            state <= simon_pkg::err_led;
                        end
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                simon_pkg::ok_on: begin
                    if (count == '0) begin
                        nl    <= '0;
                        play  <= 1'b0;
                        count <= timebase;
                        state <= simon_pkg::ok_off;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                simon_pkg::ok_off: begin
                    if (count != '0) begin
                        count <= count - 1'b1;
                    end else if (scan != max) begin
                        scan  <= scan + 1'b1;   // next key of this round
                        state <= simon_pkg::key_arm;
                    end else if (max != simon_pkg::last_step) begin
                        max      <= max + 1'b1;
                        timebase <= timebase - simon_pkg::dec_seq;
                        state    <= simon_pkg::record;
                    end else begin
                        play  <= 1'b1;          // all rounds done
                        sound <= simon_pkg::snd_win;
                        count <= simon_pkg::count_fin;
                        state <= simon_pkg::win_off;
                    end
                end
                simon_pkg::err_led: begin
                    count <= timebase;          // wrong key stays lit
                    state <= simon_pkg::err_on;
                end
                simon_pkg::err_on: begin
                    if (count == '0) begin
                        nl    <= '0;
                        play  <= 1'b0;
                        count <= timebase;
                        state <= simon_pkg::err_off;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                simon_pkg::err_off: begin
                    if (count == '0) begin
                        max   <= '0;
                        state <= simon_pkg::loss_fetch;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                simon_pkg::loss_fetch: begin
                    address <= max;     // max walks the replay up to scan
                    state   <= simon_pkg::loss_wait;
                end
                simon_pkg::loss_wait: begin
                    state <= simon_pkg::loss_show;
                end
                simon_pkg::loss_show: begin
                    nl    <= 4'b0001 << data_out;
                    play  <= 1'b1;
                    sound <= simon_pkg::sound_e'({1'b0, data_out});
                    count <= timebase;
                    state <= simon_pkg::loss_on;
                end
                simon_pkg::loss_on: begin
                    if (count == '0) begin
                        nl    <= '0;
                        play  <= 1'b0;
                        count <= timebase;
                        state <= simon_pkg::loss_off;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                simon_pkg::loss_off: begin
                    if (count != '0) begin
                        count <= count - 1'b1;
                    end else if (max != scan) begin
                        max   <= max + 1'b1;
                        state <= simon_pkg::loss_fetch;
                    end else begin
                        nl    <= 4'b0001 << data_out;   // failing step blinks
                        play  <= 1'b1;
                        sound <= simon_pkg::snd_loss;
                        count <= simon_pkg::count_fin;
                        state <= simon_pkg::final_on;
                    end
                end
                simon_pkg::final_on: begin
                    if (count == '0) begin
                        nl    <= '0;
                        play  <= 1'b0;
                        count <= simon_pkg::count_fin;
                        state <= simon_pkg::final_off;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                simon_pkg::final_off: begin
                    if (count == '0) begin
                        nl    <= 4'b0001 << data_out;
                        play  <= 1'b1;
                        sound <= simon_pkg::snd_loss;
                        count <= simon_pkg::count_fin;
                        state <= simon_pkg::final_on;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                simon_pkg::win_off: begin
                    if (count == '0) begin
                        nl    <= '1;            // all LEDs, tone off
                        play  <= 1'b0;
                        count <= simon_pkg::count_fin;
                        state <= simon_pkg::win_on;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                simon_pkg::win_on: begin
                    if (count == '0) begin
                        nl    <= '0;
                        play  <= 1'b1;
                        sound <= simon_pkg::snd_win;
                        count <= simon_pkg::count_fin;
                        state <= simon_pkg::win_off;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                default: begin
                    state <= simon_pkg::idle;
                end
            endcase
        end
    end

    one_led_outside_win: assert property (
        @(posedge clock) disable iff (!rst_n)
        (state != simon_pkg::win_on) |-> $onehot0(nl)
    );

    // only a new game clears the loss flag
    nloss_held_until_start: assert property (
        @(posedge clock) disable iff (!rst_n)
        $fell(nloss) |-> ($past(start) || !$past(rst_n))
    );

    state_encoding_legal: assert property (
        @(posedge clock) disable iff (!rst_n)
        !$isunknown(state) && (state <= simon_pkg::win_off)
    );

endmodule

`default_nettype wire

// ==== hw/simon_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module simon_top (
    input  wire         clock,
    input  wire         rst_n,
    input  wire         start,
    input  wire  [3:0]  key,
    output logic        nloss,
    output logic [3:0]  nl,
    output logic        speaker
);

    logic                          wr;
    logic [simon_pkg::addr_w-1:0]  address;
    logic [simon_pkg::color_w-1:0] data_out;
    logic                          play;
    simon_pkg::sound_e             sound;

    game_fsm game_fsm_inst (
        .clock    (clock),
        .rst_n    (rst_n),
        .start    (start),
        .key      (key),
        .data_out (data_out),
        .wr       (wr),
        .address  (address),
        .play     (play),
        .sound    (sound),
        .nl       (nl),         // LEDs straight to the player
        .nloss    (nloss)
    );

    seq_memory seq_memory_inst (
        .clock    (clock),
        .rst_n    (rst_n),
        .wr       (wr),
        .address  (address),
        .data_out (data_out)
    );

    tone_gen tone_gen_inst (
        .clock    (clock),
        .rst_n    (rst_n),
        .play     (play),
        .sound    (sound),
        .speaker  (speaker)
    );

endmodule

`default_nettype wire

// ==== bench/clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
    output logic clock,
    output logic rst_n
);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;      // 10 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clock);
        @(negedge clock);               // release away from the active edge
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== bench/simon_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module simon_tb;

    typedef enum int {act_none, act_wrong, act_timeout} action_e;
    typedef enum int {out_loss, out_win, out_replay} outcome_e;

    logic       clock;
    logic       rst_n;
    logic       start;
    logic [3:0] key;
    logic       nloss;
    logic [3:0] nl;
    logic       speaker;

    integer   seed;
    int       cycles;
    int       limit;
    string    names[$];
    int       rounds_q[$];
    action_e  actions_q[$];
    outcome_e outcomes_q[$];
    logic [simon_pkg::color_w-1:0] shown[$];   // colours learned from playback

    clock_gen clock_gen_inst (
        .clock (clock),
        .rst_n (rst_n)
    );

    simon_top simon_top_inst (
        .clock   (clock),
        .rst_n   (rst_n),
        .start   (start),
        .key     (key),
        .nloss   (nloss),
        .nl      (nl),
        .speaker (speaker)
    );

    task automatic end_with_failure();
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic report_error(input string why);
        $display("Error: %s", why);
        end_with_failure();
    endtask

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            report_error($sformatf("no result after %0d cycles, run stopped", cycles));
        end
    end

    function automatic logic [3:0] led_of(input logic [simon_pkg::color_w-1:0] colour);
        return 4'b0001 << colour;
    endfunction

    function automatic logic [simon_pkg::color_w-1:0] led_index(input logic [3:0] leds);
        logic [simon_pkg::color_w-1:0] idx;
        idx = '0;
        for (int i = 0; i < 4; i++) begin
            if (leds[i]) begin
                idx = simon_pkg::color_w'(i);
            end
        end
        return idx;
    endfunction

    task automatic check_leds(input string test, input logic [3:0] expected,
                              input logic [3:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: leds expected %b actual %b", test, expected, actual);
            end_with_failure();
        end
    endtask

    task automatic check_flag(input string test, input bit expected, input bit actual);
        if (actual !== expected) begin
            $display("Fail %s: flag expected %b actual %b", test, expected, actual);
            end_with_failure();
        end
    endtask

    task automatic check_sound(input string test, input simon_pkg::sound_e code,
                               input int measured);
        int expected;
        expected = int'(simon_pkg::tone_half[code]);
        if (measured != expected) begin
            $display("Fail %s: half-period of sound %0d expected %0d actual %0d",
                     test, code, expected, measured);
            end_with_failure();
        end
    endtask

    task automatic wait_led_on(input string test, input int max_wait);
        int n;
        n = 0;
        while (nl == 4'b0000) begin
            if (n >= max_wait) begin
                report_error($sformatf("%s: no LED lit within %0d cycles", test, max_wait));
            end
            @(negedge clock);
            n++;
        end
    endtask

    task automatic wait_leds_equal(input string test, input logic [3:0] value,
                                   input int max_wait);
        int n;
        n = 0;
        while (nl !== value) begin
            if (n >= max_wait) begin
                report_error($sformatf("%s: LEDs never showed %b within %0d cycles",
                                       test, value, max_wait));
            end
            @(negedge clock);
            n++;
        end
    endtask

    task automatic wait_loss(input string test, input int max_wait);
        int n;
        n = 0;
        while (nloss !== 1'b1) begin
            if (n >= max_wait) begin
                report_error($sformatf("%s: loss flag not raised within %0d cycles",
                                       test, max_wait));
            end
            @(negedge clock);
            n++;
        end
    endtask

    // follow one lit LED until it changes, timing speaker toggles on the way
    task automatic observe_blink(input string test, input bit loss_tone,
                                 output logic [3:0] seen);
        simon_pkg::sound_e code;
        int   n;
        int   last;
        logic prev;
        seen = nl;
        if (!$onehot(nl)) begin
            report_error($sformatf("%s: LED pattern %b is not a single colour", test, nl));
        end
        code = loss_tone ? simon_pkg::snd_loss : simon_pkg::sound_e'({1'b0, led_index(seen)});
        n    = 0;
        last = 0;               // tone starts with the LED
        prev = speaker;
        while (nl === seen) begin
            @(negedge clock);
            n++;
            if (nl === seen && speaker !== prev) begin
                check_sound(test, code, n - last);
                last = n;
                prev = speaker;
            end
        end
        // long enough for a first toggle
        if (last == 0 && n > int'(simon_pkg::tone_half[code])) begin
            report_error($sformatf("%s: speaker silent while LED %b was lit", test, seen));
        end
    endtask

    // hold the key until its LED answers
    task automatic press_key(input string test, input logic [simon_pkg::color_w-1:0] colour,
                             input int timebase);
        int delay;
        delay = 1 + ({$random(seed)} % 10);
        repeat (timebase + 1 + delay) @(negedge clock);
        key = led_of(colour);
        wait_led_on(test, int'(simon_pkg::count_key) + 4);
        key = 4'b0000;
    endtask

    task automatic run_scenario(input string test, input int rounds, input action_e action,
                                input outcome_e outcome);
        int         total;
        int         timebase;
        int         gap;
        int         steps;
        int         n;
        logic [3:0] seen;
        logic [simon_pkg::color_w-1:0] wrong;
        shown.delete();
        total = (action == act_none) ? rounds : rounds + 1;
        gap   = 3 * int'(simon_pkg::count_seq);
        $display("scenario %s: %0d rounds", test, total);
        @(negedge clock);
        start = 1'b1;
        @(negedge clock);
        start = 1'b0;
        check_flag(test, 1'b0, nloss);
        check_leds(test, 4'b0000, nl);
        wait_led_on(test, 5);
        for (int r = 1; r <= total; r++) begin
            timebase = int'(simon_pkg::count_seq) - (r - 1) * int'(simon_pkg::dec_seq);
            for (int i = 0; i < r; i++) begin
                wait_led_on(test, gap);
                observe_blink(test, 1'b0, seen);
                if (i < r - 1) begin
                    check_leds(test, led_of(shown[i]), seen);
                end else begin
                    shown.push_back(led_index(seen));   // new colour of this round
                end
                check_leds(test, 4'b0000, nl);
            end
            steps = (r == total && action != act_none) ? r - 1 : r;
            for (int s = 0; s < steps; s++) begin
                press_key(test, shown[s], timebase);
                check_leds(test, led_of(shown[s]), nl);
                check_flag(test, 1'b0, nloss);
                wait_leds_equal(test, 4'b0000, timebase + 4);
            end
        end
        if (action == act_wrong) begin
            wrong = shown[total-1] + 1'b1;
            press_key(test, wrong, timebase);
            check_leds(test, led_of(wrong), nl);
            check_flag(test, 1'b1, nloss);
            wait_leds_equal(test, 4'b0000, timebase + 4);
        end else if (action == act_timeout) begin
            wait_loss(test, timebase + int'(simon_pkg::count_key) + 10);
            check_leds(test, 4'b0000, nl);
        end
        if (outcome == out_replay) begin
            for (int i = 0; i < total; i++) begin
                wait_led_on(test, gap);
                observe_blink(test, 1'b0, seen);
                check_leds(test, led_of(shown[i]), seen);
                check_flag(test, 1'b1, nloss);
            end
            for (int b = 0; b < 2; b++) begin   // failing step blinks with the loss tone
                wait_led_on(test, gap);
                observe_blink(test, 1'b1, seen);
                check_leds(test, led_of(shown[total-1]), seen);
                check_leds(test, 4'b0000, nl);
                check_flag(test, 1'b1, nloss);
            end
        end else if (outcome == out_win) begin
            wait_leds_equal(test, 4'b1111, timebase + int'(simon_pkg::count_fin) + 10);
            check_flag(test, 1'b0, nloss);
            wait_leds_equal(test, 4'b0000, int'(simon_pkg::count_fin) + 4);
            n = 0;
            while (speaker !== 1'b1) begin
                if (n > int'(simon_pkg::count_fin) + 2) begin
                    report_error($sformatf("%s: no win tone between blinks", test));
                end
                @(negedge clock);
                n++;
            end
            check_sound(test, simon_pkg::snd_win, n);
            wait_leds_equal(test, 4'b1111, 2 * int'(simon_pkg::count_fin) + 6);
            check_flag(test, 1'b0, nloss);
        end
    endtask

    task automatic read_golden();
        int   fd;
        int   code;
        int   rounds;
        logic [8*24-1:0]  tok;
        logic [8*24-1:0]  act;
        logic [8*24-1:0]  outc;
        logic [8*128-1:0] skip;
        fd = $fopen("bench/simon_golden.txt", "r");
        if (fd == 0) begin
            report_error("cannot open bench/simon_golden.txt");
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tok);
            if (code == 1) begin
                if (tok == "#") begin
                    code = $fgets(skip, fd);    // comment line
                end else begin
                    code = $fscanf(fd, "%d %s %s", rounds, act, outc);
                    if (code != 3) begin
                        report_error("malformed line in golden file");
                    end
                    names.push_back($sformatf("%0s", tok));
                    rounds_q.push_back(rounds);
                    if (act == "wrong") begin
                        actions_q.push_back(act_wrong);
                    end else if (act == "timeout") begin
                        actions_q.push_back(act_timeout);
                    end else if (act == "none") begin
                        actions_q.push_back(act_none);
                    end else begin
                        report_error($sformatf("unknown final action %0s", act));
                    end
                    if (outc == "loss") begin
                        outcomes_q.push_back(out_loss);
                    end else if (outc == "win") begin
                        outcomes_q.push_back(out_win);
                    end else if (outc == "loss_replay_match") begin
                        outcomes_q.push_back(out_replay);
                    end else begin
                        report_error($sformatf("unknown outcome %0s", outc));
                    end
                end
            end
        end
        $fclose(fd);
    endtask

    initial begin
        int played;
        seed  = 32'h879b_1e3c;
        cycles = 0;
        limit  = 2000;
        start  = 1'b0;
        key    = 4'b0000;
        read_golden();
        foreach (names[i]) begin
            if ((actions_q[i] == act_none) != (outcomes_q[i] == out_win) ||
                (outcomes_q[i] == out_win && rounds_q[i] != simon_pkg::seq_len)) begin
                report_error($sformatf("scenario %s is inconsistent", names[i]));
            end
            played = (actions_q[i] == act_none) ? rounds_q[i] : rounds_q[i] + 1;
            limit  = limit + played * 4 * (int'(simon_pkg::count_seq) + 2) * played;
        end
        @(posedge rst_n);
        @(negedge clock);
        check_leds("reset", 4'b0000, nl);
        check_flag("reset", 1'b0, nloss);
        check_flag("reset", 1'b0, speaker);
        foreach (names[i]) begin
            run_scenario(names[i], rounds_q[i], actions_q[i], outcomes_q[i]);
        end
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/simon_golden.txt ====
# columns: test name, correct rounds before the final action,
# final action (wrong, timeout, none), expected outcome (loss, win, loss_replay_match)
first_wrong       0   wrong    loss
first_timeout     0   timeout  loss
round2_wrong      1   wrong    loss_replay_match
round3_timeout    2   timeout  loss_replay_match
round5_wrong      4   wrong    loss_replay_match
round7_timeout    6   timeout  loss
full_win          32  none     win
after_win_wrong   3   wrong    loss_replay_match

// ==== vlog.f ====
hw/simon_pkg.sv
hw/seq_memory.sv
hw/tone_gen.sv
hw/game_fsm.sv
hw/simon_top.sv
bench/clock_gen.sv
bench/simon_tb.sv

// ==== Bender.yml ====
package:
  name: simon

sources:
  - hw/simon_pkg.sv
  - hw/seq_memory.sv
  - hw/tone_gen.sv
  - hw/game_fsm.sv
  - hw/simon_top.sv
  - target: test
    files:
      - bench/clock_gen.sv
      - bench/simon_tb.sv
